//--- list.f
+incdir+verilog
verilog/svf_pkg.sv
verilog/svf_bank_mem.sv
verilog/svf_mac.sv
verilog/svf_voice_pipe.sv
verilog/svf_top.sv
verif/svf_tb.sv

//--- Bender.yml
package:
  name: svf_voices

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/svf_pkg.sv
      - verilog/svf_bank_mem.sv
      - verilog/svf_mac.sv
      - verilog/svf_voice_pipe.sv
      - verilog/svf_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/svf_tb.sv

//--- verif/svf_tb.sv
// self-checking testbench for svf_top; keeps each channel 3+ cycles apart and drains between tests
`timescale 1ns/1ns
`include "svf_consts.svh"

module svf_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 16;
	localparam int MID_RST_CYCLES = 4;
	localparam int IMPULSE_STEPS = 40;
	localparam int ROT_ROUNDS = 8;
	localparam int SHORT_ROUNDS = 2;
	localparam int DRAIN_CYCLES = `SVF_PIPE_LAT + 2;
	localparam int WATCHDOG_MARGIN = 200;
	localparam int TEST_CYCLES = RST_CYCLES + 1 + IMPULSE_STEPS * `SVF_PIPE_LAT
		+ `SVF_NCHAN * (1 + ROT_ROUNDS) + 1 + SHORT_ROUNDS * `SVF_NCHAN
		+ 1 + 2 * SHORT_ROUNDS * `SVF_NCHAN
		+ MID_RST_CYCLES + `SVF_NCHAN * (2 + 2 * SHORT_ROUNDS) + 6 * DRAIN_CYCLES;
	localparam int WATCHDOG_NS = (TEST_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD;

	typedef struct packed {
		svf_pkg::voice_tag_t tag;
		svf_pkg::sample_t sample;
		logic [31:0] arrive_edge; // edge count at which o_valid must be seen
	} expect_t;

	logic clk = 1'b0;
	logic rst;
	logic coef_wr;
	svf_pkg::coef_wr_t coef_req;
	logic in_valid;
	svf_pkg::voice_in_t voice_in;
	logic out_valid;
	svf_pkg::voice_tag_t out_tag;
	svf_pkg::sample_t out_sample;

	int seed = 32'hf83d;
	int unsigned edge_cnt = 0;
	string test_name = "reset";
	expect_t exp_q[$];
	expect_t exp_head;
	svf_pkg::coef_t ref_coef [`SVF_NNOTES];
	svf_pkg::chan_state_t ref_state [`SVF_NCHAN];
	svf_pkg::note_t chan_note [`SVF_NCHAN];

	svf_top i_dut (
		.clk(clk), .rst(rst),
		.i_coef_wr(coef_wr), .i_coef(coef_req),
		.i_valid(in_valid), .i_voice(voice_in),
		.o_valid(out_valid), .o_tag(out_tag), .o_sample(out_sample)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	// product of two state words, fraction removed, wrapped to a state word
	function automatic svf_pkg::acc_t scaled_product(input svf_pkg::acc_t a, input svf_pkg::acc_t b);
		logic signed [2*`SVF_ACC_W-1:0] full;
		full = {{`SVF_ACC_W{a[`SVF_ACC_W-1]}}, a} * {{`SVF_ACC_W{b[`SVF_ACC_W-1]}}, b};
		full = full >>> `SVF_FRAC;
		return full[`SVF_ACC_W-1:0];
	endfunction

	// one trapezoidal step; returns the output sample and the next channel state
	function automatic svf_pkg::sample_t ref_step(input svf_pkg::coef_t c,
			input svf_pkg::chan_state_t st, input svf_pkg::note_t nt,
			input svf_pkg::sample_t smp, output svf_pkg::chan_state_t nxt);
		svf_pkg::acc_t ic1;
		svf_pkg::acc_t ic2;
		svf_pkg::acc_t x;
		svf_pkg::acc_t v1;
		svf_pkg::acc_t v2;
		svf_pkg::acc_t v3;
		ic1 = (st.note == nt) ? st.ic1 : '0; // new note starts from rest
		ic2 = (st.note == nt) ? st.ic2 : '0;
		x = {{(`SVF_ACC_W-`SVF_SAMPLE_W-`SVF_IN_SHIFT){smp[`SVF_SAMPLE_W-1]}}, smp,
			{`SVF_IN_SHIFT{1'b0}}};
		v3 = x - ic2;
		v1 = scaled_product(c.a1, ic1) + scaled_product(c.a2, v3);
		v2 = ic2 + scaled_product(c.a2, ic1) + scaled_product(c.a3, v3);
		nxt.ic1 = v1 + v1 - ic1;
		nxt.ic2 = v2 + v2 - ic2;
		nxt.note = nt;
		return v2[`SVF_IN_SHIFT +: `SVF_SAMPLE_W];
	endfunction

	function automatic svf_pkg::acc_t rand_coef_word();
		return svf_pkg::acc_t'($unsigned($random(seed)) & 32'h3fff_ffff); // below 2^30
	endfunction

	task automatic compare_tag(input string name, input svf_pkg::voice_tag_t exp_v,
			input svf_pkg::voice_tag_t act_v);
		if (act_v !== exp_v) begin
			$display("MISMATCH %s tag: expected chan %0d note %0d, actual chan %0d note %0d",
				name, exp_v.chan, exp_v.note, act_v.chan, act_v.note);
			stop_on_error();
		end
	endtask

	task automatic compare_sample(input string name, input svf_pkg::sample_t exp_v,
			input svf_pkg::sample_t act_v);
		if (act_v !== exp_v) begin
			$display("MISMATCH %s sample: expected %0d, actual %0d", name, exp_v, act_v);
			stop_on_error();
		end
	endtask

	task automatic compare_arrival(input string name, input int unsigned exp_v,
			input int unsigned act_v);
		if (act_v != exp_v) begin
			$display("MISMATCH %s arrival edge: expected %0d, actual %0d", name, exp_v, act_v);
			stop_on_error();
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		in_valid <= 1'b0;
		coef_wr <= 1'b0;
	endtask

	task automatic write_coef(input svf_pkg::note_t nt);
		svf_pkg::coef_t c;
		c.a1 = rand_coef_word();
		c.a2 = rand_coef_word();
		c.a3 = rand_coef_word();
		@(posedge clk);
		in_valid <= 1'b0;
		coef_wr <= 1'b1;
		coef_req <= '{note: nt, coef: c};
		ref_coef[nt] = c;
	endtask

	task automatic send(input svf_pkg::chan_t ch, input svf_pkg::note_t nt,
			input svf_pkg::sample_t smp);
		expect_t e;
		svf_pkg::chan_state_t nxt;
		@(posedge clk);
		in_valid <= 1'b1;
		coef_wr <= 1'b0;
		voice_in <= '{chan: ch, note: nt, sample: smp};
		e.tag = '{chan: ch, note: nt};
		e.sample = ref_step(ref_coef[nt], ref_state[ch], nt, smp, nxt);
		e.arrive_edge = edge_cnt + 2 + `SVF_PIPE_LAT; // accepted at the next edge
		ref_state[ch] = nxt;
		exp_q.push_back(e);
	endtask

	task automatic run_rotation(input int rounds);
		for (int r = 0; r < rounds; r++) begin
			for (int c = 0; c < `SVF_NCHAN; c++) begin
				send(svf_pkg::chan_t'(c), chan_note[c], svf_pkg::sample_t'($random(seed)));
			end
		end
	endtask

	task automatic drain_and_check();
		repeat (DRAIN_CYCLES) idle_cycle();
		if (exp_q.size() != 0) begin
			$display("ERROR: %s ended with %0d outputs that never appeared", test_name,
				exp_q.size());
			stop_on_error();
		end
	endtask

	task automatic pulse_reset(input int cycles);
		@(posedge clk);
		rst <= 1'b1;
		in_valid <= 1'b0;
		coef_wr <= 1'b0;
		repeat (cycles - 1) @(posedge clk);
		rst <= 1'b0;
		exp_q.delete(); // in-flight inputs are dropped by the reset
		foreach (ref_state[c]) ref_state[c] = '0;
		foreach (ref_coef[n]) ref_coef[n] = '0;
	endtask

	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR: %s output for channel %0d arrived with nothing expected",
					test_name, out_tag.chan);
				stop_on_error();
			end else begin
				exp_head = exp_q.pop_front();
				compare_tag(test_name, exp_head.tag, out_tag);
				compare_sample(test_name, exp_head.sample, out_sample);
				compare_arrival(test_name, exp_head.arrive_edge, edge_cnt);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
		stop_on_error();
	end

	initial begin
		rst = 1'b1;
		coef_wr = 1'b0;
		coef_req = '0;
		in_valid = 1'b0;
		voice_in = '0;
		foreach (ref_state[c]) ref_state[c] = '0;
		foreach (ref_coef[n]) ref_coef[n] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		test_name = "impulse";
		write_coef(7'd60);
		for (int i = 0; i < IMPULSE_STEPS; i++) begin
			send(3'd0, 7'd60, (i == 0) ? 24'sh100000 : 24'sh0);
			repeat (`SVF_PIPE_LAT - 1) idle_cycle();
		end
		drain_and_check();

		test_name = "rotation";
		for (int c = 0; c < `SVF_NCHAN; c++) begin
			chan_note[c] = svf_pkg::note_t'(40 + c);
			write_coef(chan_note[c]);
		end
		run_rotation(ROT_ROUNDS);
		drain_and_check();

		test_name = "note_change";
		chan_note[3] = 7'd70; // channel 3 state must be discarded
		write_coef(7'd70);
		run_rotation(SHORT_ROUNDS);
		drain_and_check();

		test_name = "coef_rewrite";
		run_rotation(SHORT_ROUNDS);
		write_coef(7'd45);
		run_rotation(SHORT_ROUNDS);
		drain_and_check();

		test_name = "mid_reset";
		run_rotation(1);
		pulse_reset(MID_RST_CYCLES);
		for (int c = 0; c < `SVF_NCHAN; c++) chan_note[c] = svf_pkg::note_t'(40 + c);
		run_rotation(SHORT_ROUNDS); // zero table, every output is zero
		for (int c = 0; c < `SVF_NCHAN; c++) write_coef(chan_note[c]);
		run_rotation(SHORT_ROUNDS);
		repeat (DRAIN_CYCLES) idle_cycle();

		if (exp_q.size() != 0) begin
			$display("ERROR: %0d outputs never appeared at the end of the run", exp_q.size());
			stop_on_error();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- verilog/svf_top.sv
// multi voice svf top; coefficient writes reach samples accepted from the write edge onward
`timescale 1ns/1ns
`include "svf_consts.svh"

module svf_top (
	input logic clk,
	input logic rst,
	input logic i_coef_wr,
	input svf_pkg::coef_wr_t i_coef,
	input logic i_valid,
	input svf_pkg::voice_in_t i_voice,
	output logic o_valid,
	output svf_pkg::voice_tag_t o_tag,
	output svf_pkg::sample_t o_sample
);

	svf_pkg::note_t coef_idx;
	svf_pkg::coef_t coef_rd;
	svf_pkg::chan_t state_idx;
	svf_pkg::chan_state_t state_rd;
	logic state_wr;
	svf_pkg::chan_t state_wr_idx;
	svf_pkg::chan_state_t state_wr_data;
	svf_pkg::coef_t mac_coef;
	svf_pkg::acc_t mac_ic1;
	svf_pkg::acc_t mac_v3;
	svf_pkg::acc_t a1_ic1;
	svf_pkg::acc_t a2_v3;
	svf_pkg::acc_t a2_ic1;
	svf_pkg::acc_t a3_v3;

	svf_bank_mem #(.T_ENTRY(svf_pkg::coef_t), .DEPTH(`SVF_NNOTES)) u_coef_table (
		.clk(clk), .rst(rst),
		.i_wr(i_coef_wr), .i_wr_idx(i_coef.note), .i_wr_data(i_coef.coef), // host port
		.i_rd_idx(coef_idx), .o_rd_data(coef_rd)
	);

	svf_bank_mem #(.T_ENTRY(svf_pkg::chan_state_t), .DEPTH(`SVF_NCHAN)) u_state_bank (
		.clk(clk), .rst(rst),
		.i_wr(state_wr), .i_wr_idx(state_wr_idx), .i_wr_data(state_wr_data),
		.i_rd_idx(state_idx), .o_rd_data(state_rd)
	);

	svf_mac u_mac (
		.clk(clk), .rst(rst),
		.i_coef(mac_coef), .i_ic1(mac_ic1), .i_v3(mac_v3),
		.o_a1_ic1(a1_ic1), .o_a2_v3(a2_v3), .o_a2_ic1(a2_ic1), .o_a3_v3(a3_v3)
	);

	svf_voice_pipe u_pipe (
		.clk(clk), .rst(rst),
		.i_valid(i_valid), .i_voice(i_voice),
		.i_coef(coef_rd), .i_state(state_rd),
		.i_a1_ic1(a1_ic1), .i_a2_v3(a2_v3), .i_a2_ic1(a2_ic1), .i_a3_v3(a3_v3),
		.o_coef_idx(coef_idx), .o_state_idx(state_idx),
		.o_state_wr(state_wr), .o_state_wr_idx(state_wr_idx),
		.o_state_wr_data(state_wr_data),
		.o_mac_coef(mac_coef), .o_mac_ic1(mac_ic1), .o_mac_v3(mac_v3),
		.o_valid(o_valid), .o_tag(o_tag), .o_sample(o_sample)
	);

endmodule

//--- verilog/svf_voice_pipe.sv
// svf step control; one channel may not re-enter within SVF_PIPE_LAT-1 cycles, there is no state bypass
`timescale 1ns/1ns
`include "svf_consts.svh"

module svf_voice_pipe (
	input logic clk,
	input logic rst,
	input logic i_valid,
	input svf_pkg::voice_in_t i_voice,
	input svf_pkg::coef_t i_coef,
	input svf_pkg::chan_state_t i_state,
	input svf_pkg::acc_t i_a1_ic1,
	input svf_pkg::acc_t i_a2_v3,
	input svf_pkg::acc_t i_a2_ic1,
	input svf_pkg::acc_t i_a3_v3,
	output svf_pkg::note_t o_coef_idx,
	output svf_pkg::chan_t o_state_idx,
	output logic o_state_wr,
	output svf_pkg::chan_t o_state_wr_idx,
	output svf_pkg::chan_state_t o_state_wr_data,
	output svf_pkg::coef_t o_mac_coef,
	output svf_pkg::acc_t o_mac_ic1,
	output svf_pkg::acc_t o_mac_v3,
	output logic o_valid,
	output svf_pkg::voice_tag_t o_tag,
	output svf_pkg::sample_t o_sample
);

	svf_pkg::voice_in_t r_in; // accepted input, addresses both banks
	logic r_in_valid;
	logic note_hit;
	svf_pkg::acc_t cur_ic1;
	svf_pkg::acc_t cur_ic2;
	svf_pkg::acc_t x;
	svf_pkg::acc_t v3;

	logic s1_valid;
	svf_pkg::voice_tag_t s1_tag;
	svf_pkg::coef_t s1_coef;
	svf_pkg::acc_t s1_ic1;
	svf_pkg::acc_t s1_ic2;
	svf_pkg::acc_t s1_v3;

	logic s2_valid; // lines up with the multiply results
	svf_pkg::voice_tag_t s2_tag;
	svf_pkg::acc_t s2_ic1;
	svf_pkg::acc_t s2_ic2;

	svf_pkg::acc_t v1;
	svf_pkg::acc_t v2;
	svf_pkg::acc_t new_ic1;
	svf_pkg::acc_t new_ic2;

	assign o_coef_idx = r_in.note;
	assign o_state_idx = r_in.chan;

	// a new note restarts the voice from zero integrators
	always_comb begin
		note_hit = (i_state.note == r_in.note);
		cur_ic1 = note_hit ? i_state.ic1 : '0;
		cur_ic2 = note_hit ? i_state.ic2 : '0;
		x = svf_pkg::acc_t'(r_in.sample) <<< `SVF_IN_SHIFT;
		v3 = x - cur_ic2;
	end

	assign o_mac_coef = s1_coef;
	assign o_mac_ic1 = s1_ic1;
	assign o_mac_v3 = s1_v3;

	// trapezoidal update, all sums wrap at the state word width
	always_comb begin
		v1 = i_a1_ic1 + i_a2_v3;
		v2 = s2_ic2 + i_a2_ic1 + i_a3_v3;
		new_ic1 = (v1 <<< 1) - s2_ic1;
		new_ic2 = (v2 <<< 1) - s2_ic2;
	end

	assign o_state_wr = s2_valid;
	assign o_state_wr_idx = s2_tag.chan;
	assign o_state_wr_data = '{ic1: new_ic1, ic2: new_ic2, note: s2_tag.note};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			r_in_valid <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			r_in_valid <= i_valid;
			s1_valid <= r_in_valid;
			s2_valid <= s1_valid;
			o_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		r_in <= i_voice;
		s1_tag <= '{chan: r_in.chan, note: r_in.note};
		s1_coef <= i_coef;
		s1_ic1 <= cur_ic1;
		s1_ic2 <= cur_ic2;
		s1_v3 <= v3;
		s2_tag <= s1_tag;
		s2_ic1 <= s1_ic1;
		s2_ic2 <= s1_ic2;
		o_tag <= s2_tag;
		o_sample <= svf_pkg::sample_t'(v2 >>> `SVF_IN_SHIFT); // low 24 bits of the rescaled v2
	end

	// writeback lands SVF_PIPE_LAT edges after acceptance, earlier re-entry reads stale state
	for (genvar k = 1; k < `SVF_PIPE_LAT; k++) begin : g_spacing
		a_chan_spacing: assert property (@(posedge clk) disable iff (rst)
			(i_valid && $past(i_valid, k)) |-> (i_voice.chan != $past(i_voice.chan, k)))
			else $error("channel %0d re-entered %0d cycles after its last input", i_voice.chan, k);
	end

	a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(o_valid))
		else $error("o_valid unknown after reset");

endmodule

//--- verilog/svf_mac.sv
// four signed products per cycle, one register stage; results wrap at the state word width
`timescale 1ns/1ns
`include "svf_consts.svh"

module svf_mac (
	input logic clk,
	input logic rst,
	input svf_pkg::coef_t i_coef,
	input svf_pkg::acc_t i_ic1,
	input svf_pkg::acc_t i_v3,
	output svf_pkg::acc_t o_a1_ic1,
	output svf_pkg::acc_t o_a2_v3,
	output svf_pkg::acc_t o_a2_ic1,
	output svf_pkg::acc_t o_a3_v3
);

	svf_pkg::prod_t p_a1_ic1;
	svf_pkg::prod_t p_a2_v3;
	svf_pkg::prod_t p_a2_ic1;
	svf_pkg::prod_t p_a3_v3;

	// drop the coefficient fraction, keep the low state word bits
	function automatic svf_pkg::acc_t scale(input svf_pkg::prod_t p);
		return svf_pkg::acc_t'(p >>> `SVF_FRAC);
	endfunction

	// operands sign extended to full product width first
	always_comb begin
		p_a1_ic1 = svf_pkg::prod_t'(i_coef.a1) * svf_pkg::prod_t'(i_ic1);
		p_a2_v3 = svf_pkg::prod_t'(i_coef.a2) * svf_pkg::prod_t'(i_v3);
		p_a2_ic1 = svf_pkg::prod_t'(i_coef.a2) * svf_pkg::prod_t'(i_ic1);
		p_a3_v3 = svf_pkg::prod_t'(i_coef.a3) * svf_pkg::prod_t'(i_v3);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_a1_ic1 <= '0;
			o_a2_v3 <= '0;
			o_a2_ic1 <= '0;
			o_a3_v3 <= '0;
		end else begin
			o_a1_ic1 <= scale(p_a1_ic1); // v1 terms
			o_a2_v3 <= scale(p_a2_v3);
			o_a2_ic1 <= scale(p_a2_ic1); // v2 terms
			o_a3_v3 <= scale(p_a3_v3);
		end
	end

endmodule

//--- verilog/svf_bank_mem.sv
// register bank with combinational read and reset clear; DEPTH must be at least 2
`timescale 1ns/1ns

module svf_bank_mem #(
	parameter type T_ENTRY = logic,
	parameter int DEPTH = 8,
	localparam int IDX_W = $clog2(DEPTH)
) (
	input logic clk,
	input logic rst,
	input logic i_wr,
	input logic [IDX_W-1:0] i_wr_idx,
	input T_ENTRY i_wr_data,
	input logic [IDX_W-1:0] i_rd_idx,
	output T_ENTRY o_rd_data
);

	T_ENTRY mem [DEPTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (i_wr) begin
			mem[i_wr_idx] <= i_wr_data;
		end
	end

	// a write shows up on the read port after its edge
	assign o_rd_data = mem[i_rd_idx];

	// an unknown index hits no defined entry
	// non power of two depths leave index codes with no entry behind them
	a_wr_idx_range: assert property (@(posedge clk) disable iff (rst)
		i_wr |-> (!$isunknown(i_wr_idx) && (int'(i_wr_idx) < DEPTH)))
		else $error("bank write index %0d unknown or outside depth %0d", i_wr_idx, DEPTH);

endmodule

//--- verilog/svf_pkg.sv
// shared filter types; struct field order fixes the packed layout the host and testbench drive
`include "svf_consts.svh"

package svf_pkg;

	// scalar words
	typedef logic signed [`SVF_SAMPLE_W-1:0] sample_t;
	typedef logic signed [`SVF_ACC_W-1:0] acc_t;
	typedef logic signed [2*`SVF_ACC_W-1:0] prod_t; // full acc_t by acc_t product
	typedef logic [`SVF_NOTE_W-1:0] note_t;
	typedef logic [`SVF_CHAN_W-1:0] chan_t;

	// coefficient triple for one note, Q3.31
	typedef struct packed {
		acc_t a1;
		acc_t a2;
		acc_t a3;
	} coef_t;

	// per channel integrators plus the note they were built for
	typedef struct packed {
		acc_t ic1;
		acc_t ic2;
		note_t note;
	} chan_state_t;

	typedef struct packed {
		chan_t chan;
		note_t note;
		sample_t sample;
	} voice_in_t;

	typedef struct packed {
		chan_t chan;
		note_t note;
	} voice_tag_t;

	typedef struct packed {
		note_t note; // table row
		coef_t coef;
	} coef_wr_t;

endpackage

//--- verilog/svf_consts.svh
// integer build constants; SVF_CHAN_W and SVF_NOTE_W must equal clog2 of SVF_NCHAN and SVF_NNOTES
`ifndef SVF_CONSTS_SVH
`define SVF_CONSTS_SVH

// voices and notes
`define SVF_NCHAN 8 // time-multiplexed voice channels
`define SVF_CHAN_W 3
`define SVF_NOTE_W 7 // midi note number
`define SVF_NNOTES 128 // one coefficient triple per note

// datapath widths
`define SVF_SAMPLE_W 24 // audio in and out
`define SVF_ACC_W 35 // integrator and coefficient word

// fixed point
// coefficients carry 31 fractional bits, so every product is
// shifted back by that amount before it is summed
`define SVF_FRAC 31
`define SVF_IN_SHIFT 9 // sample to state word headroom

// cycles from the accepting edge to the edge raising o_valid,
// also the minimum spacing between inputs of one channel
`define SVF_PIPE_LAT 3

`endif
